// ==== source/xc_defs.svh ====
// Cross-correlator parameters
`ifndef XC_DEFS_SVH
`define XC_DEFS_SVH

// Detector lines on the two connectors.
`define XC_NUM_LINES 8

// Lag taps 0 to 3 per line.
`define XC_LAGS 4

// Counter width in bits.
`define XC_RESOLUTION 24

// Sysclk cycles per sample tick.
`define XC_SAMPLE_DIV 16

// Captured samples per frame.
`define XC_FRAME_SAMPLES 1024

// Sysclk cycles per UART bit.
`define XC_BAUD_DIV 8

// Frame start marker.
`define XC_SYNC_BYTE 8'hA5

// Auto counters first, then one cross counter per line.
`define XC_NUM_COUNTERS (`XC_NUM_LINES * `XC_LAGS + `XC_NUM_LINES)

`endif

// ==== source/xc_pkg.sv ====
// Cross-correlator types
`include "xc_defs.svh"

package xc_pkg;

	typedef logic [`XC_NUM_LINES-1:0] sample_t;    // One bit per line.
	typedef logic [`XC_RESOLUTION-1:0] count_t;    // Coincidence count.
	typedef logic [$clog2(`XC_NUM_COUNTERS)-1:0] counter_index_t;
	typedef logic [7:0] uart_byte_t;               // Serial payload.

	// Readout sequencing.
	typedef enum logic [2:0] {
		sender_idle,
		sender_sync,   // Marker byte.
		sender_high,   // Count bits 23..16.
		sender_mid,    // Count bits 15..8.
		sender_low     // Count bits 7..0.
	} sender_state_t;

	// Serial bit phases, 8N1.
	typedef enum logic [1:0] {
		uart_idle,
		uart_start,
		uart_data,
		uart_stop
	} uart_state_t;

endpackage

// ==== source/line_sampler.sv ====
// Detector line sampler
`include "xc_defs.svh"

module line_sampler (
	input  logic            sysclk,
	input  logic            reset,
	input  xc_pkg::sample_t lines,           // Asynchronous detector inputs.
	input  logic            strobe,          // Asynchronous capture gate.
	output xc_pkg::sample_t sample,          // Held until the next tick.
	output logic            sample_capture,
	output logic            sample_valid
);
	import xc_pkg::*;

	localparam int DIV_W = $clog2(`XC_SAMPLE_DIV);

	sample_t lines_meta;     // First stage, may be metastable.
	sample_t lines_sync;
	logic strobe_meta;
	logic strobe_sync;
	logic [DIV_W-1:0] div_count;
	logic tick;

	// Two-flop synchronizers for lines and strobe.
	always_ff @(posedge sysclk) begin
		if (reset) begin
			lines_meta <= '0;
			lines_sync <= '0;
			strobe_meta <= 1'b0;
			strobe_sync <= 1'b0;
		end else begin
			lines_meta <= lines;
			lines_sync <= lines_meta;
			strobe_meta <= strobe;
			strobe_sync <= strobe_meta;
		end
	end

	// Terminal count of the sample divider.
	assign tick = (div_count == DIV_W'(`XC_SAMPLE_DIV - 1));

	always_ff @(posedge sysclk) begin
		if (reset) begin
			div_count <= '0;
			sample <= '0;
			sample_capture <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			div_count <= tick ? '0 : div_count + 1'b1;
			sample_valid <= tick;              // Lands with the new word.
			if (tick) begin
				sample <= lines_sync;          // Also drives the echo pins.
				sample_capture <= strobe_sync;
			end
		end
	end

endmodule

// ==== source/delay_line.sv ====
// Sample history and lag taps
`include "xc_defs.svh"

module delay_line (
	input  logic                           sysclk,
	input  logic                           reset,
	input  xc_pkg::sample_t                sample,
	input  logic                           sample_capture,
	input  logic                           sample_valid,
	output xc_pkg::sample_t [`XC_LAGS-1:0] taps,        // Index 0 is newest.
	output logic                           taps_capture,
	output logic                           taps_valid
);

	// Lag window doubles as the history.
	// Every tick shifts, captured or not, so lags span gaps and frames.
	always_ff @(posedge sysclk) begin
		if (reset) begin
			taps <= '0;
			taps_capture <= 1'b0;
			taps_valid <= 1'b0;
		end else begin
			taps_valid <= sample_valid;        // One cycle behind the sample.
			if (sample_valid) begin
				taps <= {taps[`XC_LAGS-2:0], sample};   // Oldest drops out.
				taps_capture <= sample_capture;
			end
		end
	end

	// Tick is a single-cycle strobe.
	// A held valid would shift the window twice per sample.
	sample_valid_pulse: assert property (
		@(posedge sysclk) disable iff (reset)
		sample_valid |=> !sample_valid
	);

endmodule

// ==== source/correlator.sv ====
// Coincidence counters and snapshot bank
`include "xc_defs.svh"

module correlator (
	input  logic                           sysclk,
	input  logic                           reset,
	input  xc_pkg::sample_t [`XC_LAGS-1:0] taps,
	input  logic                           taps_capture,
	input  logic                           taps_valid,
	input  xc_pkg::counter_index_t         read_index,
	output xc_pkg::count_t                 read_count,
	output logic                           frame_ready
);
	import xc_pkg::*;

	localparam int AUTO_COUNTERS = `XC_NUM_LINES * `XC_LAGS;   // Cross bank starts here.
	localparam int FRAME_W = $clog2(`XC_FRAME_SAMPLES + 1);

	count_t counters [`XC_NUM_COUNTERS];     // Live frame.
	count_t next_count [`XC_NUM_COUNTERS];
	count_t snapshot [`XC_NUM_COUNTERS];     // Frozen for readout.
	logic [`XC_NUM_COUNTERS-1:0] hits;
	logic [FRAME_W-1:0] sample_count;        // Captured samples this frame.
	logic count_en;
	logic frame_end;

	// Coincidence rules.
	always_comb begin
		for (int l = 0; l < `XC_NUM_LINES; l++) begin
			// Auto: high now and high k ticks earlier.
			for (int k = 0; k < `XC_LAGS; k++) begin
				hits[l * `XC_LAGS + k] = taps[0][l] & taps[k][l];
			end
			// Cross: high together with the next line, wrapping at the top.
			hits[AUTO_COUNTERS + l] = taps[0][l] & taps[0][(l + 1) % `XC_NUM_LINES];
		end
	end

	always_comb begin
		for (int i = 0; i < `XC_NUM_COUNTERS; i++) begin
			next_count[i] = counters[i] + count_t'(hits[i]);
		end
	end

	assign count_en = taps_valid & taps_capture;    // Strobe low counts nothing.
	assign frame_end = count_en && (sample_count == FRAME_W'(`XC_FRAME_SAMPLES - 1));

	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int i = 0; i < `XC_NUM_COUNTERS; i++) begin
				counters[i] <= '0;
			end
			sample_count <= '0;
			frame_ready <= 1'b0;
		end else begin
			frame_ready <= frame_end;          // Snapshot visible from here.
			if (frame_end) begin
				for (int i = 0; i < `XC_NUM_COUNTERS; i++) begin
					counters[i] <= '0;
				end
				sample_count <= '0;
			end else if (count_en) begin
				for (int i = 0; i < `XC_NUM_COUNTERS; i++) begin
					counters[i] <= next_count[i];
				end
				sample_count <= sample_count + 1'b1;
			end
		end
	end

	// Snapshot includes the closing sample.
	always_ff @(posedge sysclk) begin
		if (frame_end) begin
			for (int i = 0; i < `XC_NUM_COUNTERS; i++) begin
				snapshot[i] <= next_count[i];
			end
		end
	end

	assign read_count = snapshot[read_index];   // Sender only walks 0..39.

	// Frame closes before the count can run past its length.
	sample_count_bound: assert property (
		@(posedge sysclk) disable iff (reset)
		sample_count < FRAME_W'(`XC_FRAME_SAMPLES)
	);

endmodule

// ==== source/frame_sender.sv ====
// Snapshot readout sequencer
`include "xc_defs.svh"

module frame_sender (
	input  logic                   sysclk,
	input  logic                   reset,
	input  logic                   frame_ready,
	output xc_pkg::counter_index_t read_index,
	input  xc_pkg::count_t         read_count,
	output logic                   tx_start,
	output xc_pkg::uart_byte_t     tx_byte,
	input  logic                   tx_busy
);
	import xc_pkg::*;

	sender_state_t state;
	logic last_index;

	assign last_index = (read_index == counter_index_t'(`XC_NUM_COUNTERS - 1));

	// Each state hands one byte over and moves on once the UART takes it.
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= sender_idle;
			read_index <= '0;
		end else begin
			case (state)
				sender_idle: begin
					if (frame_ready) begin
						state <= sender_sync;
						read_index <= '0;
					end
				end
				sender_sync: begin
					if (!tx_busy) state <= sender_high;
				end
				sender_high: begin
					if (!tx_busy) state <= sender_mid;
				end
				sender_mid: begin
					if (!tx_busy) state <= sender_low;
				end
				sender_low: begin
					if (!tx_busy) begin
						if (last_index) begin
							state <= sender_idle;     // Frame done.
						end else begin
							read_index <= read_index + 1'b1;
							state <= sender_high;
						end
					end
				end
				default: state <= sender_idle;
			endcase
		end
	end

	// Start fires whenever the UART is free in a sending state.
	assign tx_start = (state != sender_idle) && !tx_busy;

	// Most significant byte first.
	always_comb begin
		case (state)
			sender_high: tx_byte = read_count[`XC_RESOLUTION-1 -: 8];
			sender_mid:  tx_byte = read_count[`XC_RESOLUTION-9 -: 8];
			sender_low:  tx_byte = read_count[7:0];
			default:     tx_byte = `XC_SYNC_BYTE;
		endcase
	end

	// Readout must finish within one frame period.
	no_frame_overrun: assert property (
		@(posedge sysclk) disable iff (reset)
		frame_ready |-> (state == sender_idle)
	);

endmodule

// ==== source/uart_tx.sv ====
// UART transmitter
`include "xc_defs.svh"

module uart_tx (
	input  logic               sysclk,
	input  logic               reset,
	input  logic               tx_start,
	input  xc_pkg::uart_byte_t tx_byte,
	output logic               tx_busy,
	output logic               tx             // Idles high.
);
	import xc_pkg::*;

	localparam int BAUD_W = $clog2(`XC_BAUD_DIV);

	uart_state_t state;
	uart_byte_t shift;                       // LSB goes out first.
	logic [BAUD_W-1:0] baud_count;
	logic [2:0] bit_count;                   // Data bit number.
	logic bit_end;

	assign bit_end = (baud_count == BAUD_W'(`XC_BAUD_DIV - 1));

	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= uart_idle;
			baud_count <= '0;
			bit_count <= '0;
		end else begin
			baud_count <= (state == uart_idle || bit_end) ? '0 : baud_count + 1'b1;
			case (state)
				uart_idle:  if (tx_start) state <= uart_start;
				uart_start: begin
					if (bit_end) begin
						state <= uart_data;
						bit_count <= '0;
					end
				end
				uart_data: begin
					if (bit_end) begin
						bit_count <= bit_count + 1'b1;
						if (bit_count == 3'd7) state <= uart_stop;
					end
				end
				uart_stop:  if (bit_end) state <= uart_idle;
				default:    state <= uart_idle;
			endcase
		end
	end

	always_ff @(posedge sysclk) begin
		if (state == uart_idle && tx_start) shift <= tx_byte;
		else if (state == uart_data && bit_end) shift <= shift >> 1;
	end

	assign tx_busy = (state != uart_idle);

	always_comb begin
		case (state)
			uart_start: tx = 1'b0;
			uart_data:  tx = shift[0];
			default:    tx = 1'b1;       // Idle and stop bit.
		endcase
	end

	// Sender waits for the UART to be free.
	start_when_free: assert property (
		@(posedge sysclk) disable iff (reset)
		tx_start |-> !tx_busy
	);

endmodule

// ==== source/xc_firmware.sv ====
// Cross-correlator top level
`include "xc_defs.svh"

module xc_firmware (
	input  logic        sysclk,
	input  logic        reset,
	input  logic [19:0] jp1_in,
	input  logic [19:0] jp2_in,
	output logic [19:0] jp1_out,
	output logic [19:0] jp2_out
);
	import xc_pkg::*;

	sample_t lines;
	logic strobe;
	sample_t sample;
	logic sample_capture;
	logic sample_valid;                      // Also the smpclk pin.
	sample_t [`XC_LAGS-1:0] taps;
	logic taps_capture;
	logic taps_valid;
	counter_index_t read_index;
	count_t read_count;
	logic frame_ready;
	logic tx_start;
	uart_byte_t tx_byte;
	logic tx_busy;
	logic tx;

	// Odd pins carry lines, even pins echo them back.
	assign lines = {jp2_in[9], jp2_in[11], jp2_in[13], jp2_in[15],
		jp1_in[9], jp1_in[11], jp1_in[13], jp1_in[15]};
	assign strobe = jp2_in[16];

	always_comb begin
		jp1_out = '0;                        // Unused pins low.
		jp1_out[14] = sample[0];
		jp1_out[12] = sample[1];
		jp1_out[10] = sample[2];
		jp1_out[8] = sample[3];
		jp1_out[19] = sample_valid;          // smpclk.
		jp2_out = '0;
		jp2_out[14] = sample[4];
		jp2_out[12] = sample[5];
		jp2_out[10] = sample[6];
		jp2_out[8] = sample[7];
		jp2_out[18] = tx;                    // UART TX.
	end

	line_sampler sampler_block (.sysclk, .reset, .lines, .strobe,
		.sample, .sample_capture, .sample_valid);

	delay_line delay_block (.sysclk, .reset, .sample, .sample_capture, .sample_valid,
		.taps, .taps_capture, .taps_valid);

	correlator correlator_block (.sysclk, .reset, .taps, .taps_capture, .taps_valid,
		.read_index, .read_count, .frame_ready);

	frame_sender sender_block (.sysclk, .reset, .frame_ready, .read_index, .read_count,
		.tx_start, .tx_byte, .tx_busy);

	uart_tx uart_block (.sysclk, .reset, .tx_start, .tx_byte, .tx_busy, .tx);

endmodule

// ==== tests/xc_tb.sv ====
// Cross-correlator testbench
`include "xc_defs.svh"

module xc_tb;

	localparam int CLK_HALF = 10;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_FRAMES = 3;
	localparam int LINES = `XC_NUM_LINES;
	localparam int LAGS = `XC_LAGS;
	localparam int TICK_TIMEOUT = 2 * `XC_SAMPLE_DIV;
	localparam int BYTE_TIMEOUT = 4 * `XC_BAUD_DIV;
	localparam int FRAME_TIMEOUT = 3 * `XC_FRAME_SAMPLES * `XC_SAMPLE_DIV;
	localparam int RUN_TIMEOUT = 2 * (NUM_FRAMES + 1) * `XC_FRAME_SAMPLES * `XC_SAMPLE_DIV;
	localparam int IDLE_TAIL = 20 * `XC_BAUD_DIV;          // Two byte times.
	localparam time SAMPLE_PERIOD = 2 * CLK_HALF * `XC_SAMPLE_DIV;
	localparam logic [19:0] JP1_USED = 20'h85500;          // smpclk and echo pins.
	localparam logic [19:0] JP2_USED = 20'h45500;          // TX and echo pins.
	localparam int GAP_START = 1500;                        // Strobe low inside frame 2.
	localparam int GAP_LEN = 37;
	localparam int GAP2_START = 2700;                       // Short gap in frame 3.
	localparam int GAP2_LEN = 5;

	logic sysclk;
	logic reset;
	logic [19:0] jp1_in;
	logic [19:0] jp2_in;
	logic [19:0] jp1_out;
	logic [19:0] jp2_out;
	logic tx;
	logic smpclk;

	logic [31:0] lfsr;
	logic [7:0] lines_drv;                   // Word held for the current period.
	logic strobe_drv;
	int tick_index;
	int captured_samples;
	int frames_received;
	logic [7:0] history [LAGS];              // Index 0 is the newest sample.
	logic [23:0] model_counts [`XC_NUM_COUNTERS];
	logic [23:0] expected_counts [$];        // Frozen frames, 40 per frame.
	time freeze_times [$];

	assign tx = jp2_out[18];
	assign smpclk = jp1_out[19];

	xc_firmware UUT (
		.sysclk,
		.reset,
		.jp1_in,
		.jp2_in,
		.jp1_out,
		.jp2_out
	);

	initial begin
		sysclk = 1'b0;
		forever begin
			#CLK_HALF sysclk = ~sysclk;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected));
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0.
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_lines(output logic [7:0] word);
		for (int i = 0; i < LINES; i++) begin
			lfsr = next_lfsr(lfsr);      // One step per bit.
			word[i] = lfsr[0];
		end
	endtask

	function automatic logic in_gap(input int t);
		return (t >= GAP_START && t < GAP_START + GAP_LEN) ||
			(t >= GAP2_START && t < GAP2_START + GAP2_LEN);
	endfunction

	// Lines on odd pins 15 down to 9, strobe on jp2 bit 16.
	task automatic drive_inputs(input logic [7:0] word, input logic gate);
		logic [19:0] pins1;
		logic [19:0] pins2;
		pins1 = '0;
		pins2 = '0;
		for (int i = 0; i < 4; i++) begin
			pins1[15 - 2 * i] = word[i];
			pins2[15 - 2 * i] = word[i + 4];
		end
		pins2[16] = gate;
		jp1_in = pins1;
		jp2_in = pins2;
	endtask

	function automatic logic [7:0] read_echo();
		logic [7:0] word;
		for (int i = 0; i < 4; i++) begin
			word[i] = jp1_out[14 - 2 * i];     // Even pins one below the input.
			word[i + 4] = jp2_out[14 - 2 * i];
		end
		return word;
	endfunction

	// Reference model, one call per sample tick.
	task automatic update_model(input logic [7:0] word, input logic captured);
		for (int k = LAGS - 1; k > 0; k--) begin
			history[k] = history[k - 1];     // Shifts even with strobe low.
		end
		history[0] = word;
		if (captured) begin
			for (int l = 0; l < LINES; l++) begin
				for (int k = 0; k < LAGS; k++) begin
					if (history[0][l] && history[k][l]) model_counts[l * LAGS + k]++;
				end
				if (history[0][l] && history[0][(l + 1) % LINES]) begin
					model_counts[LINES * LAGS + l]++;   // Neighbor, wraps at line 7.
				end
			end
			captured_samples++;
			if (captured_samples == `XC_FRAME_SAMPLES) begin
				for (int i = 0; i < `XC_NUM_COUNTERS; i++) begin
					expected_counts.push_back(model_counts[i]);
					model_counts[i] = '0;
				end
				freeze_times.push_back($time);
				captured_samples = 0;
			end
		end
	endtask

	// Returns 2 units after the edge that raised smpclk.
	task automatic wait_sample_tick();
		int waited;
		waited = 0;
		do begin
			@(posedge sysclk);
			#2;
			waited++;
			if (smpclk !== 1'b1 && waited > TICK_TIMEOUT) abort_run("no smpclk pulse in time");
		end while (smpclk !== 1'b1);
	endtask

	// 8N1 decode, sampled mid-bit on falling clock edges.
	task automatic receive_byte(input int timeout_cycles, output logic [7:0] value,
		output time started);
		int waited;
		waited = 0;
		do begin
			@(negedge sysclk);
			waited++;
			if (tx !== 1'b0 && waited > timeout_cycles) abort_run("no UART start bit in time");
		end while (tx !== 1'b0);
		started = $time;
		repeat (`XC_BAUD_DIV / 2) @(negedge sysclk);
		check_value("tx start bit", 32'(tx), 32'h0);
		for (int i = 0; i < 8; i++) begin
			repeat (`XC_BAUD_DIV) @(negedge sysclk);
			value[i] = tx;                     // LSB first.
		end
		repeat (`XC_BAUD_DIV) @(negedge sysclk);
		check_value("tx stop bit", 32'(tx), 32'h1);
	endtask

	initial begin : main_sequence
		int waited;
		lfsr = 32'he727;
		lines_drv = '0;
		strobe_drv = 1'b1;
		tick_index = 0;
		frames_received = 0;
		reset = 1'b1;
		drive_inputs(lines_drv, strobe_drv);
		repeat (RESET_CYCLES) @(posedge sysclk);
		#2;
		reset = 1'b0;
		check_value("jp1_out after reset", 32'(jp1_out), 32'h0);   // smpclk and echo low.
		check_value("jp2_out after reset", 32'(jp2_out), 32'h40000); // Only TX high.
		waited = 0;
		while (frames_received < NUM_FRAMES) begin
			@(posedge sysclk);
			waited++;
			if (waited > RUN_TIMEOUT) abort_run("timed out waiting for all frames");
		end
		repeat (IDLE_TAIL) begin
			@(negedge sysclk);
			check_value("tx after last frame", 32'(tx), 32'h1);   // No byte past 120.
		end
		$display("Everything OK");
		$finish;
	end

	initial begin : stimulus
		int waited;
		waited = 0;
		captured_samples = 0;
		for (int k = 0; k < LAGS; k++) begin
			history[k] = '0;
		end
		for (int i = 0; i < `XC_NUM_COUNTERS; i++) begin
			model_counts[i] = '0;
		end
		do begin
			@(posedge sysclk);
			waited++;
			if (reset !== 1'b0 && waited > 4 * RESET_CYCLES) abort_run("reset never released");
		end while (reset !== 1'b0);
		forever begin
			wait_sample_tick();
			check_value("echo lines", 32'(read_echo()), 32'(lines_drv));
			check_value("jp1_out unused bits", 32'(jp1_out & ~JP1_USED), 32'h0);
			check_value("jp2_out unused bits", 32'(jp2_out & ~JP2_USED), 32'h0);
			update_model(lines_drv, strobe_drv);
			tick_index++;
			draw_lines(lines_drv);             // Next period's word.
			strobe_drv = !in_gap(tick_index);
			drive_inputs(lines_drv, strobe_drv);
		end
	end

	initial begin : uart_receiver
		logic [7:0] rx;
		logic [23:0] count;
		time started;
		int waited;
		waited = 0;
		do begin
			@(negedge sysclk);
			waited++;
			if (reset !== 1'b0 && waited > 4 * RESET_CYCLES) abort_run("reset never released");
		end while (reset !== 1'b0);
		forever begin
			receive_byte(FRAME_TIMEOUT, rx, started);
			check_value("tx sync byte", 32'(rx), 32'(`XC_SYNC_BYTE));
			if (freeze_times.size() == 0) abort_run("frame sent before 1024 captured samples");
			if (started - freeze_times[0] > SAMPLE_PERIOD) begin
				abort_run("frame sent later than one sample after its last captured sample");
			end
			void'(freeze_times.pop_front());
			for (int i = 0; i < `XC_NUM_COUNTERS; i++) begin
				count = expected_counts.pop_front();
				for (int b = 2; b >= 0; b--) begin
					receive_byte(BYTE_TIMEOUT, rx, started);   // High byte first.
					check_value($sformatf("tx count %0d byte %0d", i, b), 32'(rx),
						32'(count[8 * b +: 8]));
				end
			end
			frames_received++;
		end
	end

endmodule

// ==== vlog.f ====
+incdir+source
source/xc_pkg.sv
source/line_sampler.sv
source/delay_line.sv
source/correlator.sv
source/frame_sender.sv
source/uart_tx.sv
source/xc_firmware.sv
tests/xc_tb.sv

// ==== Makefile ====
TOP = xc_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 --assert --top-module $(TOP) -f vlog.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir
